/* design/csr_pkg.sv */
package csr_pkg;

    typedef logic [31:0] xlen_t;     // One CSR data word
    typedef logic [11:0] csr_addr_t;

    // Access port commands
    typedef enum logic [3:0] {
        cmd_none       = 4'd0,
        cmd_read       = 4'd1,
        cmd_write      = 4'd2,
        cmd_read_write = 4'd3,
        cmd_read_set   = 4'd4,  // Read, then OR in the write data
        cmd_read_clear = 4'd5   // Read, then clear the write data bits
    } csr_cmd_t;

    // Machine information, read only space
    localparam csr_addr_t addr_mvendorid = 12'hF11;
    localparam csr_addr_t addr_marchid   = 12'hF12;
    localparam csr_addr_t addr_mimpid    = 12'hF13;
    localparam csr_addr_t addr_mhartid   = 12'hF14;

    // Machine trap setup
    localparam csr_addr_t addr_mstatus   = 12'h300;
    localparam csr_addr_t addr_misa      = 12'h301;
    localparam csr_addr_t addr_mie       = 12'h304;
    localparam csr_addr_t addr_mtvec     = 12'h305;

    // Machine trap handling
    localparam csr_addr_t addr_mscratch  = 12'h340;
    localparam csr_addr_t addr_mepc      = 12'h341;
    localparam csr_addr_t addr_mcause    = 12'h342;
    localparam csr_addr_t addr_mtval     = 12'h343;
    localparam csr_addr_t addr_mip       = 12'h344;

    // Counters, split into halves
    localparam csr_addr_t addr_mcycle    = 12'hB00;
    localparam csr_addr_t addr_minstret  = 12'hB02;
    localparam csr_addr_t addr_mcycleh   = 12'hB80;
    localparam csr_addr_t addr_minstreth = 12'hB82;

    // MSTATUS fields
    localparam int unsigned mie_bit  = 3;
    localparam int unsigned mpie_bit = 7;
    localparam int unsigned mpp_lsb  = 11;
    localparam logic [1:0]  mpp_machine = 2'b11; // Only machine mode exists

    // MIE and MIP bit positions
    localparam int unsigned msi_bit = 3;
    localparam int unsigned mti_bit = 7;
    localparam int unsigned mei_bit = 11;

    // MXL = 32 bit, extensions U, S, M and I; the A bit is ORed in at run time
    localparam xlen_t misa_fixed = 32'h4014_1100;

    // MTVEC and MEPC need these low bits clear
    localparam int unsigned align_mask_bits = 2;

    // Value of every writable register after reset
    localparam xlen_t reset_word = 32'h0000_0000;

endpackage

/* design/csr_access.sv */
`timescale 1ns/1ns

module csr_access (
    input  csr_pkg::csr_cmd_t  csr_cmd,
    input  csr_pkg::csr_addr_t csr_address,
    input  csr_pkg::xlen_t     csr_writedata,

    input  logic               hit_regs,
    input  logic               hit_cycle,
    input  logic               hit_instret,
    input  logic               hit_irq,

    input  csr_pkg::xlen_t     rdata_regs,
    input  csr_pkg::xlen_t     rdata_cycle,
    input  csr_pkg::xlen_t     rdata_instret,
    input  csr_pkg::xlen_t     rdata_irq,

    output csr_pkg::xlen_t     csr_readdata,
    output logic               csr_invalid,
    output logic               write_en,
    output csr_pkg::xlen_t     wdata
);

    logic read_op;
    logic write_op;
    logic any_hit;
    logic ro_write;

    // Command decode
    always_comb begin
        read_op  = 1'b0;
        write_op = 1'b0;
        case (csr_cmd)
            csr_pkg::cmd_read: begin
                read_op = 1'b1;
            end
            csr_pkg::cmd_write: begin
                write_op = 1'b1;
            end
            csr_pkg::cmd_read_write,
            csr_pkg::cmd_read_set,
            csr_pkg::cmd_read_clear: begin
                read_op  = 1'b1;
                write_op = 1'b1;
            end
            default: begin
                read_op  = 1'b0;
                write_op = 1'b0;
            end
        endcase
    end

    // Unaddressed blocks return zero, so an OR is enough
    assign csr_readdata = rdata_regs | rdata_cycle | rdata_instret | rdata_irq;

    assign any_hit  = hit_regs | hit_cycle | hit_instret | hit_irq;
    assign ro_write = write_op && (csr_address[11:10] == 2'b11); // Read-only space

    assign csr_invalid = ((read_op || write_op) && !any_hit) || ro_write;
    assign write_en    = write_op && !csr_invalid;

    // Read-modify-write data for set and clear
    always_comb begin
        case (csr_cmd)
            csr_pkg::cmd_write,
            csr_pkg::cmd_read_write: wdata = csr_writedata;
            csr_pkg::cmd_read_set:   wdata = csr_readdata | csr_writedata;
            csr_pkg::cmd_read_clear: wdata = csr_readdata & ~csr_writedata;
            default:                 wdata = '0;
        endcase
    end

    // Register blocks decode disjoint address sets
    always_comb begin
        assert final (csr_cmd != csr_pkg::cmd_none || !csr_invalid)
            else $error("csr_invalid raised without a command");
        assert final ($onehot0({hit_regs, hit_cycle, hit_instret, hit_irq}))
            else $error("more than one register block claims address %h", csr_address);
    end

endmodule

/* design/csr_machine_regs.sv */
`timescale 1ns/1ns

module csr_machine_regs #(
    parameter csr_pkg::xlen_t mvendorid = 32'h0A1A_A1E0,
    parameter csr_pkg::xlen_t marchid   = 32'h0000_0001,
    parameter csr_pkg::xlen_t mimpid    = 32'h0000_0001,
    parameter csr_pkg::xlen_t mhartid   = 32'h0000_0000
) (
    input  logic               clk,
    input  logic               rst_n,
    input  csr_pkg::csr_addr_t csr_address,
    input  logic               write_en,
    input  csr_pkg::xlen_t     wdata,
    output logic               hit,
    output csr_pkg::xlen_t     rdata,
    output logic               mstatus_mie
);

    logic           mstatus_mpie;
    logic           misa_atomic;  // Scratch bit, lets machine code emulate A
    csr_pkg::xlen_t mtvec;
    csr_pkg::xlen_t mepc;
    csr_pkg::xlen_t mscratch;
    csr_pkg::xlen_t mcause;
    csr_pkg::xlen_t mtval;
    csr_pkg::xlen_t mstatus_word;
    logic           wdata_aligned;

    assign wdata_aligned = (wdata[csr_pkg::align_mask_bits-1:0] == '0);

    // MPP is hardwired to machine
    always_comb begin
        mstatus_word = '0;
        mstatus_word[csr_pkg::mie_bit]      = mstatus_mie;
        mstatus_word[csr_pkg::mpie_bit]     = mstatus_mpie;
        mstatus_word[csr_pkg::mpp_lsb +: 2] = csr_pkg::mpp_machine;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mstatus_mie  <= 1'b0;
            mstatus_mpie <= 1'b0;
            misa_atomic  <= 1'b0;
            mtvec        <= csr_pkg::reset_word;
            mepc         <= csr_pkg::reset_word;
            mscratch     <= csr_pkg::reset_word;
            mcause       <= csr_pkg::reset_word;
            mtval        <= csr_pkg::reset_word;
        end else if (write_en) begin
            case (csr_address)
                csr_pkg::addr_mstatus: begin
                    mstatus_mie  <= wdata[csr_pkg::mie_bit];
                    mstatus_mpie <= wdata[csr_pkg::mpie_bit];
                end
                csr_pkg::addr_misa: begin
                    misa_atomic <= wdata[0];
                end
                csr_pkg::addr_mtvec: begin
                    if (wdata_aligned)
                        mtvec <= wdata;
                end
                csr_pkg::addr_mepc: begin
                    if (wdata_aligned)
                        mepc <= wdata;
                end
                csr_pkg::addr_mscratch: mscratch <= wdata;
                csr_pkg::addr_mcause:   mcause   <= wdata;
                csr_pkg::addr_mtval:    mtval    <= wdata;
                default: begin
                end
            endcase
        end
    end

    // Read mux and hit decode
    always_comb begin
        hit   = 1'b1;
        rdata = '0;
        case (csr_address)
            csr_pkg::addr_mvendorid: rdata = mvendorid;
            csr_pkg::addr_marchid:   rdata = marchid;
            csr_pkg::addr_mimpid:    rdata = mimpid;
            csr_pkg::addr_mhartid:   rdata = mhartid;
            csr_pkg::addr_mstatus:   rdata = mstatus_word;
            csr_pkg::addr_misa:      rdata = csr_pkg::misa_fixed | {31'b0, misa_atomic};
            csr_pkg::addr_mtvec:     rdata = mtvec;
            csr_pkg::addr_mepc:      rdata = mepc;
            csr_pkg::addr_mscratch:  rdata = mscratch;
            csr_pkg::addr_mcause:    rdata = mcause;
            csr_pkg::addr_mtval:     rdata = mtval;
            default: begin
                hit   = 1'b0;
                rdata = '0;
            end
        endcase
    end

endmodule

/* design/csr_counter.sv */
`timescale 1ns/1ns

module csr_counter #(
    parameter csr_pkg::csr_addr_t addr_lo = csr_pkg::addr_mcycle,
    parameter csr_pkg::csr_addr_t addr_hi = csr_pkg::addr_mcycleh
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               incr,
    input  csr_pkg::csr_addr_t csr_address,
    input  logic               write_en,
    input  csr_pkg::xlen_t     wdata,
    output logic               hit,
    output csr_pkg::xlen_t     rdata
);

    logic [63:0] count;
    logic [63:0] count_inc;
    logic        sel_lo;
    logic        sel_hi;

    assign sel_lo = (csr_address == addr_lo);
    assign sel_hi = (csr_address == addr_hi);
    assign hit    = sel_lo | sel_hi;

    assign count_inc = count + {63'b0, incr}; // Carry runs into the high half

    // A half write overrides only that half of the incremented value
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            count <= '0;
        end else begin
            count <= count_inc;
            if (write_en && sel_lo)
                count[31:0] <= wdata;
            if (write_en && sel_hi)
                count[63:32] <= wdata;
        end
    end

    always_comb begin
        if (sel_lo)
            rdata = count[31:0];
        else if (sel_hi)
            rdata = count[63:32];
        else
            rdata = '0;
    end

    assert property (@(posedge clk) disable iff (!rst_n)
        $past(rst_n) && !$past(write_en && hit) |-> count >= $past(count))
        else $error("counter at %h/%h went backwards", addr_hi, addr_lo);

endmodule

/* design/csr_irq_ctrl.sv */
`timescale 1ns/1ns

module csr_irq_ctrl (
    input  logic               clk,
    input  logic               rst_n,
    input  csr_pkg::csr_addr_t csr_address,
    input  logic               write_en,
    input  csr_pkg::xlen_t     wdata,
    input  logic               mstatus_mie,
    input  logic               irq_timer_i,
    input  logic               irq_exti_i,
    input  logic               irq_swi_i,
    output logic               hit,
    output csr_pkg::xlen_t     rdata,
    output logic               irq_timer_en,
    output logic               irq_exti_en,
    output logic               irq_swi_en,
    output logic               timer_pending,
    output logic               exti_pending,
    output logic               swi_pending
);

    logic mie_msie;
    logic mie_mtie;
    logic mie_meie;
    logic mip_msip;
    logic mip_mtip;
    logic mip_meip;
    logic sel_mie;
    logic sel_mip;

    assign sel_mie = (csr_address == csr_pkg::addr_mie);
    assign sel_mip = (csr_address == csr_pkg::addr_mip);
    assign hit     = sel_mie | sel_mip;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mie_msie <= 1'b0;
            mie_mtie <= 1'b0;
            mie_meie <= 1'b0;
            mip_msip <= 1'b0;
            mip_mtip <= 1'b0;
            mip_meip <= 1'b0;
        end else begin
            mip_msip <= irq_swi_i;   // MIP tracks the lines, writes are dropped
            mip_mtip <= irq_timer_i;
            mip_meip <= irq_exti_i;
            if (write_en && sel_mie) begin
                mie_msie <= wdata[csr_pkg::msi_bit];
                mie_mtie <= wdata[csr_pkg::mti_bit];
                mie_meie <= wdata[csr_pkg::mei_bit];
            end
        end
    end

    always_comb begin
        rdata = '0;
        if (sel_mie) begin
            rdata[csr_pkg::msi_bit] = mie_msie;
            rdata[csr_pkg::mti_bit] = mie_mtie;
            rdata[csr_pkg::mei_bit] = mie_meie;
        end else if (sel_mip) begin
            rdata[csr_pkg::msi_bit] = mip_msip;
            rdata[csr_pkg::mti_bit] = mip_mtip;
            rdata[csr_pkg::mei_bit] = mip_meip;
        end
    end

    // Global enable gates each source
    assign irq_timer_en = mstatus_mie & mie_mtie;
    assign irq_exti_en  = mstatus_mie & mie_meie;
    assign irq_swi_en   = mstatus_mie & mie_msie;

    assign timer_pending = irq_timer_en & mip_mtip;
    assign exti_pending  = irq_exti_en & mip_meip;
    assign swi_pending   = irq_swi_en & mip_msip;

    // Pending needs the enable now and the line one cycle back
    assert property (@(posedge clk) disable iff (!rst_n)
        timer_pending |-> irq_timer_en && $past(irq_timer_i));
    assert property (@(posedge clk) disable iff (!rst_n)
        exti_pending |-> irq_exti_en && $past(irq_exti_i));
    assert property (@(posedge clk) disable iff (!rst_n)
        swi_pending |-> irq_swi_en && $past(irq_swi_i));

endmodule

/* design/csr_file.sv */
`timescale 1ns/1ns

module csr_file #(
    parameter csr_pkg::xlen_t mvendorid = 32'h0A1A_A1E0,
    parameter csr_pkg::xlen_t marchid   = 32'h0000_0001,
    parameter csr_pkg::xlen_t mimpid    = 32'h0000_0001,
    parameter csr_pkg::xlen_t mhartid   = 32'h0000_0000
) (
    input  logic               clk,
    input  logic               rst_n,

    input  csr_pkg::csr_cmd_t  csr_cmd,
    input  csr_pkg::csr_addr_t csr_address,
    input  csr_pkg::xlen_t     csr_writedata,
    output csr_pkg::xlen_t     csr_readdata,
    output logic               csr_invalid,

    input  logic               instret_incr,

    input  logic               irq_timer_i,
    input  logic               irq_exti_i,
    input  logic               irq_swi_i,
    output logic               irq_timer_en,
    output logic               irq_exti_en,
    output logic               irq_swi_en,
    output logic               timer_pending,
    output logic               exti_pending,
    output logic               swi_pending
);

    logic           write_en;
    csr_pkg::xlen_t wdata;
    logic           mstatus_mie;

    logic           hit_regs;
    logic           hit_cycle;
    logic           hit_instret;
    logic           hit_irq;
    csr_pkg::xlen_t rdata_regs;
    csr_pkg::xlen_t rdata_cycle;
    csr_pkg::xlen_t rdata_instret;
    csr_pkg::xlen_t rdata_irq;

    csr_access i_access (
        .csr_cmd       (csr_cmd),
        .csr_address   (csr_address),
        .csr_writedata (csr_writedata),
        .hit_regs      (hit_regs),
        .hit_cycle     (hit_cycle),
        .hit_instret   (hit_instret),
        .hit_irq       (hit_irq),
        .rdata_regs    (rdata_regs),
        .rdata_cycle   (rdata_cycle),
        .rdata_instret (rdata_instret),
        .rdata_irq     (rdata_irq),
        .csr_readdata  (csr_readdata),
        .csr_invalid   (csr_invalid),
        .write_en      (write_en),
        .wdata         (wdata)
    );

    csr_machine_regs #(
        .mvendorid (mvendorid),
        .marchid   (marchid),
        .mimpid    (mimpid),
        .mhartid   (mhartid)
    ) i_machine_regs (
        .clk         (clk),
        .rst_n       (rst_n),
        .csr_address (csr_address),
        .write_en    (write_en),
        .wdata       (wdata),
        .hit         (hit_regs),
        .rdata       (rdata_regs),
        .mstatus_mie (mstatus_mie)
    );

    // Cycle counter runs every clock
    csr_counter #(
        .addr_lo (csr_pkg::addr_mcycle),
        .addr_hi (csr_pkg::addr_mcycleh)
    ) i_cycle (
        .clk         (clk),
        .rst_n       (rst_n),
        .incr        (1'b1),
        .csr_address (csr_address),
        .write_en    (write_en),
        .wdata       (wdata),
        .hit         (hit_cycle),
        .rdata       (rdata_cycle)
    );

    csr_counter #(
        .addr_lo (csr_pkg::addr_minstret),
        .addr_hi (csr_pkg::addr_minstreth)
    ) i_instret (
        .clk         (clk),
        .rst_n       (rst_n),
        .incr        (instret_incr),
        .csr_address (csr_address),
        .write_en    (write_en),
        .wdata       (wdata),
        .hit         (hit_instret),
        .rdata       (rdata_instret)
    );

    csr_irq_ctrl i_irq_ctrl (
        .clk           (clk),
        .rst_n         (rst_n),
        .csr_address   (csr_address),
        .write_en      (write_en),
        .wdata         (wdata),
        .mstatus_mie   (mstatus_mie),
        .irq_timer_i   (irq_timer_i),
        .irq_exti_i    (irq_exti_i),
        .irq_swi_i     (irq_swi_i),
        .hit           (hit_irq),
        .rdata         (rdata_irq),
        .irq_timer_en  (irq_timer_en),
        .irq_exti_en   (irq_exti_en),
        .irq_swi_en    (irq_swi_en),
        .timer_pending (timer_pending),
        .exti_pending  (exti_pending),
        .swi_pending   (swi_pending)
    );

endmodule

/* dv/csr_checker.sv */
`timescale 1ns/1ns

module csr_checker #(
    parameter csr_pkg::xlen_t mvendorid = 32'h0,
    parameter csr_pkg::xlen_t marchid   = 32'h0,
    parameter csr_pkg::xlen_t mimpid    = 32'h0,
    parameter csr_pkg::xlen_t mhartid   = 32'h0
) (
    input  logic               clk,
    input  logic               rst_n,
    input  csr_pkg::csr_cmd_t  csr_cmd,
    input  csr_pkg::csr_addr_t csr_address,
    input  csr_pkg::xlen_t     csr_writedata,
    input  csr_pkg::xlen_t     csr_readdata,
    input  logic               csr_invalid,
    input  logic               instret_incr,
    input  logic               irq_timer_i,
    input  logic               irq_exti_i,
    input  logic               irq_swi_i,
    input  logic               irq_timer_en,
    input  logic               irq_exti_en,
    input  logic               irq_swi_en,
    input  logic               timer_pending,
    input  logic               exti_pending,
    input  logic               swi_pending,
    output logic               ready,
    output int                 check_count,
    output int                 mismatch_count,
    output int                 error_count
);

    // MXL of 1 plus the U, S, M and I letters, A left clear
    localparam csr_pkg::xlen_t misa_base = (32'd1 << 30) | (32'd1 << 20) | (32'd1 << 18)
                                         | (32'd1 << 12) | (32'd1 << 8);

    logic           m_mie;
    logic           m_mpie;
    logic           m_atomic;
    csr_pkg::xlen_t m_mtvec;
    csr_pkg::xlen_t m_mepc;
    csr_pkg::xlen_t m_mscratch;
    csr_pkg::xlen_t m_mcause;
    csr_pkg::xlen_t m_mtval;
    logic [2:0]     m_ie;      // External, timer, software
    logic [2:0]     m_ip;
    logic [63:0]    m_cycle;
    logic [63:0]    m_instret;

    function automatic logic known_addr(input csr_pkg::csr_addr_t a);
        return a inside {csr_pkg::addr_mvendorid, csr_pkg::addr_marchid, csr_pkg::addr_mimpid,
                         csr_pkg::addr_mhartid, csr_pkg::addr_mstatus, csr_pkg::addr_misa,
                         csr_pkg::addr_mie, csr_pkg::addr_mtvec, csr_pkg::addr_mscratch,
                         csr_pkg::addr_mepc, csr_pkg::addr_mcause, csr_pkg::addr_mtval,
                         csr_pkg::addr_mip, csr_pkg::addr_mcycle, csr_pkg::addr_mcycleh,
                         csr_pkg::addr_minstret, csr_pkg::addr_minstreth};
    endfunction

    function automatic csr_pkg::xlen_t model_read(input csr_pkg::csr_addr_t a);
        csr_pkg::xlen_t v;
        v = '0;
        case (a)
            csr_pkg::addr_mvendorid: v = mvendorid;
            csr_pkg::addr_marchid:   v = marchid;
            csr_pkg::addr_mimpid:    v = mimpid;
            csr_pkg::addr_mhartid:   v = mhartid;
            csr_pkg::addr_mstatus: begin
                v[3]     = m_mie;
                v[7]     = m_mpie;
                v[12:11] = 2'b11;   // MPP always machine
            end
            csr_pkg::addr_misa:      v = misa_base | {31'b0, m_atomic};
            csr_pkg::addr_mie:       v = {20'b0, m_ie[2], 3'b0, m_ie[1], 3'b0, m_ie[0], 3'b0};
            csr_pkg::addr_mip:       v = {20'b0, m_ip[2], 3'b0, m_ip[1], 3'b0, m_ip[0], 3'b0};
            csr_pkg::addr_mtvec:     v = m_mtvec;
            csr_pkg::addr_mepc:      v = m_mepc;
            csr_pkg::addr_mscratch:  v = m_mscratch;
            csr_pkg::addr_mcause:    v = m_mcause;
            csr_pkg::addr_mtval:     v = m_mtval;
            csr_pkg::addr_mcycle:    v = m_cycle[31:0];
            csr_pkg::addr_mcycleh:   v = m_cycle[63:32];
            csr_pkg::addr_minstret:  v = m_instret[31:0];
            csr_pkg::addr_minstreth: v = m_instret[63:32];
            default:                 v = '0;
        endcase
        return v;
    endfunction

    // Counters are already incremented when this runs
    task automatic apply_write(input csr_pkg::csr_addr_t a, input csr_pkg::xlen_t v);
        case (a)
            csr_pkg::addr_mstatus: begin
                m_mie  = v[3];
                m_mpie = v[7];
            end
            csr_pkg::addr_misa:      m_atomic = v[0];
            csr_pkg::addr_mie:       m_ie = {v[11], v[7], v[3]};
            csr_pkg::addr_mtvec:     if (v[1:0] == 2'b00) m_mtvec = v;
            csr_pkg::addr_mepc:      if (v[1:0] == 2'b00) m_mepc = v;
            csr_pkg::addr_mscratch:  m_mscratch = v;
            csr_pkg::addr_mcause:    m_mcause = v;
            csr_pkg::addr_mtval:     m_mtval = v;
            csr_pkg::addr_mcycle:    m_cycle[31:0] = v;
            csr_pkg::addr_mcycleh:   m_cycle[63:32] = v;
            csr_pkg::addr_minstret:  m_instret[31:0] = v;
            csr_pkg::addr_minstreth: m_instret[63:32] = v;
            default: begin
            end
        endcase
    endtask

    task automatic compare_word(input string name, input csr_pkg::xlen_t got,
                                input csr_pkg::xlen_t exp);
        if (got !== exp) begin
            mismatch_count++;
            $display("mismatch %s: got 0x%h, expected 0x%h (addr 0x%h, cmd %0d, t=%0t)",
                     name, got, exp, csr_address, csr_cmd, $time);
        end
    endtask

    // Inputs change just after the rising edge, so the falling edge sees them settled
    always @(negedge clk) begin
        logic           is_read;
        logic           is_write;
        logic           exp_invalid;
        logic [2:0]     exp_en;
        logic [2:0]     exp_pend;
        csr_pkg::xlen_t exp_rdata;
        csr_pkg::xlen_t new_value;
        if (!rst_n) begin
            ready          = 1'b0;
            check_count    = 0;
            mismatch_count = 0;
            error_count    = 0;
            m_mie          = 1'b0;
            m_mpie         = 1'b0;
            m_atomic       = 1'b0;
            m_mtvec        = '0;
            m_mepc         = '0;
            m_mscratch     = '0;
            m_mcause       = '0;
            m_mtval        = '0;
            m_ie           = '0;
            m_ip           = '0;
            m_cycle        = '0;
            m_instret      = '0;
        end else begin
            ready = 1'b1;
            check_count++;
            is_read  = csr_cmd inside {csr_pkg::cmd_read, csr_pkg::cmd_read_write,
                                       csr_pkg::cmd_read_set, csr_pkg::cmd_read_clear};
            is_write = csr_cmd inside {csr_pkg::cmd_write, csr_pkg::cmd_read_write,
                                       csr_pkg::cmd_read_set, csr_pkg::cmd_read_clear};
            exp_rdata   = model_read(csr_address);
            exp_invalid = ((is_read || is_write) && !known_addr(csr_address))
                          || (is_write && csr_address[11:10] == 2'b11);
            exp_en   = {3{m_mie}} & m_ie;
            exp_pend = exp_en & m_ip;

            if ($isunknown({csr_readdata, csr_invalid, irq_timer_en, irq_exti_en, irq_swi_en,
                            timer_pending, exti_pending, swi_pending})) begin
                error_count++;
                $display("DUT outputs hold unknown bits at %0t", $time);
            end
            compare_word("csr_readdata", csr_readdata, exp_rdata);
            compare_word("csr_invalid", {31'b0, csr_invalid}, {31'b0, exp_invalid});
            compare_word("irq_swi_en", {31'b0, irq_swi_en}, {31'b0, exp_en[0]});
            compare_word("irq_timer_en", {31'b0, irq_timer_en}, {31'b0, exp_en[1]});
            compare_word("irq_exti_en", {31'b0, irq_exti_en}, {31'b0, exp_en[2]});
            compare_word("swi_pending", {31'b0, swi_pending}, {31'b0, exp_pend[0]});
            compare_word("timer_pending", {31'b0, timer_pending}, {31'b0, exp_pend[1]});
            compare_word("exti_pending", {31'b0, exti_pending}, {31'b0, exp_pend[2]});

            case (csr_cmd)
                csr_pkg::cmd_read_set:   new_value = exp_rdata | csr_writedata;
                csr_pkg::cmd_read_clear: new_value = exp_rdata & ~csr_writedata;
                default:                 new_value = csr_writedata;
            endcase

            // State after the coming rising edge
            m_cycle   = m_cycle + 64'd1;
            m_instret = m_instret + {63'b0, instret_incr};
            m_ip      = {irq_exti_i, irq_timer_i, irq_swi_i};
            if (is_write && !exp_invalid)
                apply_write(csr_address, new_value);
        end
    end

endmodule

/* dv/csr_file_tb.sv */
`timescale 1ns/1ns

module csr_file_tb;

    localparam csr_pkg::xlen_t vendor_id = 32'h0000_0B1E;
    localparam csr_pkg::xlen_t arch_id   = 32'h0000_0021;
    localparam csr_pkg::xlen_t impl_id   = 32'h0000_0107;
    localparam csr_pkg::xlen_t hart_id   = 32'h0000_0003;
    localparam int             num_cmds  = 2000;

    logic               clk;
    logic               rst_n;
    csr_pkg::csr_cmd_t  csr_cmd;
    csr_pkg::csr_addr_t csr_address;
    csr_pkg::xlen_t     csr_writedata;
    csr_pkg::xlen_t     csr_readdata;
    logic               csr_invalid;
    logic               instret_incr;
    logic               irq_timer_i;
    logic               irq_exti_i;
    logic               irq_swi_i;
    logic               irq_timer_en;
    logic               irq_exti_en;
    logic               irq_swi_en;
    logic               timer_pending;
    logic               exti_pending;
    logic               swi_pending;
    logic               checker_ready;
    int                 check_count;
    int                 mismatch_count;
    int                 error_count;
    integer             seed;
    csr_pkg::csr_addr_t addr_list [17];

    always #5 clk = ~clk;

    csr_file #(
        .mvendorid (vendor_id),
        .marchid   (arch_id),
        .mimpid    (impl_id),
        .mhartid   (hart_id)
    ) i_csr_file (
        .clk           (clk),
        .rst_n         (rst_n),
        .csr_cmd       (csr_cmd),
        .csr_address   (csr_address),
        .csr_writedata (csr_writedata),
        .csr_readdata  (csr_readdata),
        .csr_invalid   (csr_invalid),
        .instret_incr  (instret_incr),
        .irq_timer_i   (irq_timer_i),
        .irq_exti_i    (irq_exti_i),
        .irq_swi_i     (irq_swi_i),
        .irq_timer_en  (irq_timer_en),
        .irq_exti_en   (irq_exti_en),
        .irq_swi_en    (irq_swi_en),
        .timer_pending (timer_pending),
        .exti_pending  (exti_pending),
        .swi_pending   (swi_pending)
    );

    csr_checker #(
        .mvendorid (vendor_id),
        .marchid   (arch_id),
        .mimpid    (impl_id),
        .mhartid   (hart_id)
    ) i_checker (
        .clk            (clk),
        .rst_n          (rst_n),
        .csr_cmd        (csr_cmd),
        .csr_address    (csr_address),
        .csr_writedata  (csr_writedata),
        .csr_readdata   (csr_readdata),
        .csr_invalid    (csr_invalid),
        .instret_incr   (instret_incr),
        .irq_timer_i    (irq_timer_i),
        .irq_exti_i     (irq_exti_i),
        .irq_swi_i      (irq_swi_i),
        .irq_timer_en   (irq_timer_en),
        .irq_exti_en    (irq_exti_en),
        .irq_swi_en     (irq_swi_en),
        .timer_pending  (timer_pending),
        .exti_pending   (exti_pending),
        .swi_pending    (swi_pending),
        .ready          (checker_ready),
        .check_count    (check_count),
        .mismatch_count (mismatch_count),
        .error_count    (error_count)
    );

    task automatic drive_random_cmd();
        logic [31:0] r;
        int          idx;
        r = $unsigned($random(seed)) % 32'd6;
        csr_cmd = csr_pkg::csr_cmd_t'(r[3:0]);
        r = $random(seed);
        if (r[3:0] < 4'd13) begin
            idx = int'($unsigned($random(seed)) % 32'd17);
            csr_address = addr_list[idx];
        end else begin
            csr_address = r[15:4];   // Mostly unknown addresses
        end
        r = $random(seed);
        if (r[2:0] == 3'd0)
            csr_writedata = 32'hFFFF_FFF0 | {28'b0, r[7:4]};  // Pushes counters to a carry
        else
            csr_writedata = $random(seed);
        r = $random(seed);
        if (r[1:0] == 2'd0) begin
            irq_timer_i = r[2];
            irq_exti_i  = r[3];
            irq_swi_i   = r[4];
        end
        instret_incr = r[5];
    endtask

    initial begin
        int target;
        int wait_count;
        seed          = 75645;
        target        = 0;
        clk           = 1'b0;
        rst_n         = 1'b0;
        csr_cmd       = csr_pkg::cmd_none;
        csr_address   = '0;
        csr_writedata = '0;
        instret_incr  = 1'b0;
        irq_timer_i   = 1'b0;
        irq_exti_i    = 1'b0;
        irq_swi_i     = 1'b0;
        addr_list = '{csr_pkg::addr_mvendorid, csr_pkg::addr_marchid, csr_pkg::addr_mimpid,
                      csr_pkg::addr_mhartid, csr_pkg::addr_mstatus, csr_pkg::addr_misa,
                      csr_pkg::addr_mie, csr_pkg::addr_mtvec, csr_pkg::addr_mscratch,
                      csr_pkg::addr_mepc, csr_pkg::addr_mcause, csr_pkg::addr_mtval,
                      csr_pkg::addr_mip, csr_pkg::addr_mcycle, csr_pkg::addr_mcycleh,
                      csr_pkg::addr_minstret, csr_pkg::addr_minstreth};

        repeat (8) @(posedge clk);
        #1 rst_n = 1'b1;

        wait_count = 0;
        while (checker_ready !== 1'b1 && wait_count < 20) begin
            @(posedge clk);
            wait_count++;
        end

        if (checker_ready === 1'b1) begin
            for (int n = 0; n < num_cmds; n++) begin
                @(posedge clk);
                #1;
                drive_random_cmd();
            end
            target = check_count + 1;   // Last command still to be compared
            wait_count = 0;
            while (check_count < target && wait_count < 10) begin
                @(posedge clk);
                wait_count++;
            end
        end

        if (checker_ready !== 1'b1)
            $display("timed out waiting for the checker to see reset released");
        else if (check_count < target)
            $display("timed out waiting for the last command to be checked");
        $display("checks %0d, mismatches %0d, other errors %0d",
                 check_count, mismatch_count, error_count);
        if (checker_ready === 1'b1 && check_count >= target && mismatch_count == 0
            && error_count == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

/* vlog.f */
design/csr_pkg.sv
design/csr_access.sv
design/csr_machine_regs.sv
design/csr_counter.sv
design/csr_irq_ctrl.sv
design/csr_file.sv
dv/csr_checker.sv
dv/csr_file_tb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -f vlog.f --top-module csr_file_tb -o csr_file_tb_sim

./obj_dir/csr_file_tb_sim > sim.log 2>&1 || { cat sim.log; exit 1; }
cat sim.log

if grep -q '\*\* FAIL \*\*' sim.log; then
    exit 1
fi
exit 0
